//--- list.f
+incdir+logic
logic/heapPkg.sv
logic/machinePkg.sv
logic/heapMemory.sv
logic/heapArbiter.sv
logic/arrayAllocator.sv
logic/arraySearch.sv
logic/programExecutor.sv
logic/arrayMachine.sv
verification/arrayMachineTb.sv

//--- logic/arrayAllocator.sv
//--------------------------------------------------------------------------
// Hands out array numbers, freed ones first, and tracks each array length
// Freeing an array that is not live is not detected
//--------------------------------------------------------------------------
`timescale 1ns/100ps
`include "machine_defs.svh"

module arrayAllocator (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  allocStrobe,
  output machinePkg::arrayNum_t allocArray,
  output logic                  allocFail,
  input  logic                  freeStrobe,
  input  machinePkg::arrayNum_t freeArray,
  input  logic                  lengthWrite,
  input  machinePkg::arrayNum_t lengthArray,
  input  machinePkg::index_t    lengthIndex,
  input  machinePkg::arrayNum_t queryArray,
  output machinePkg::length_t   arrayLength
);
  import machinePkg::*;

  localparam int COUNT_BITS = $clog2(`ARRAY_COUNT) + 1;

  logic [COUNT_BITS-1:0] allocCount;             // Fresh arrays handed out
  logic [COUNT_BITS-1:0] freedTop;               // Entries on the freed stack
  arrayNum_t             freedStack [`ARRAY_COUNT];
  length_t               lengths [`ARRAY_COUNT];
  logic                  reuse;
  length_t               grown;

  assign reuse       = freedTop != '0;
  assign allocArray  = reuse ? freedStack[arrayNum_t'(freedTop - 1'b1)]
                             : arrayNum_t'(allocCount);
  assign allocFail   = !reuse && allocCount == COUNT_BITS'(`ARRAY_COUNT);
  assign arrayLength = lengths[queryArray];
  assign grown       = length_t'(lengthIndex) + 1'b1;

  always_ff @(posedge clk) begin
    if (reset) begin
      allocCount <= '0;
      freedTop   <= '0;
    end else if (allocStrobe && !allocFail) begin
      if (reuse) begin
        freedTop <= freedTop - 1'b1;             // Pop
      end else begin
        allocCount <= allocCount + 1'b1;
      end
    end else if (freeStrobe) begin
      freedTop <= freedTop + 1'b1;               // Push
    end
  end

  always_ff @(posedge clk) begin
    if (freeStrobe) begin
      freedStack[arrayNum_t'(freedTop)] <= freeArray;
    end
    if (allocStrobe && !allocFail) begin
      lengths[allocArray] <= '0;                 // New arrays start empty
    end else if (lengthWrite && grown > lengths[lengthArray]) begin
      lengths[lengthArray] <= grown;
    end
  end

  assert property (@(posedge clk) disable iff (reset)
    freeStrobe |-> freedTop < COUNT_BITS'(`ARRAY_COUNT));

endmodule

//--- logic/arrayMachine.sv
//--------------------------------------------------------------------------
// Array machine top level; load the program while reset is high
// The peek port shares the heap with the executor and the searcher
//--------------------------------------------------------------------------
`timescale 1ns/100ps
`include "machine_defs.svh"

module arrayMachine (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       progWrite,
  input  logic [`PROG_ADDR_BITS-1:0] progAddress,
  input  logic [`INSTR_WIDTH-1:0]    progData,
  input  logic                       peekRequest,
  input  logic [`HEAP_ADDR_BITS-1:0] peekAddress,
  output logic                       peekGrant,
  output logic                       peekValid,
  output logic [`MEM_WIDTH-1:0]      peekData,
  output logic                       outValid,
  output logic [`MEM_WIDTH-1:0]      outData,
  output logic                       finished,
  output logic                       fault
);
  import heapPkg::*;
  import machinePkg::*;

  logic                       execRequest;
  logic                       execWrite;
  logic [`HEAP_ADDR_BITS-1:0] execAddress;
  logic [`MEM_WIDTH-1:0]      execData;
  logic                       searchRequest;
  logic [`HEAP_ADDR_BITS-1:0] searchAddress;
  logic [2:0]                 request;
  logic [2:0]                 write;
  logic [2:0]                 grant;
  logic [2:0]                 dataValid;
  logic [`MEM_WIDTH-1:0]      readData;
  logic                       memEnable;
  heapOp_t                    memWrite;
  logic [`HEAP_ADDR_BITS-1:0] memAddress;
  logic [`MEM_WIDTH-1:0]      memIn;
  logic [`MEM_WIDTH-1:0]      memOut;
  logic                       allocStrobe;
  arrayNum_t                  allocArray;
  logic                       allocFail;
  logic                       freeStrobe;
  arrayNum_t                  freeArray;
  logic                       lengthWrite;
  arrayNum_t                  lengthArray;
  index_t                     lengthIndex;
  arrayNum_t                  queryArray;
  length_t                    arrayLength;
  logic                       searchStart;
  arrayNum_t                  searchArray;
  logic [`MEM_WIDTH-1:0]      searchKey;
  logic                       searchDone;
  length_t                    searchResult;

  assign request[peerExec]   = execRequest;
  assign request[peerSearch] = searchRequest;
  assign request[peerPeek]   = peekRequest;
  assign write               = {2'b00, execWrite};   // Only the executor writes
  assign peekGrant           = grant[peerPeek];
  assign peekValid           = dataValid[peerPeek];
  assign peekData            = readData;

  programExecutor executor (
    .clk, .reset, .progWrite, .progAddress, .progData,
    .heapRequest(execRequest), .heapWrite(execWrite),
    .heapAddress(execAddress), .heapData(execData),
    .heapGrant(grant[peerExec]), .heapDataValid(dataValid[peerExec]),
    .heapReadData(readData),
    .allocStrobe, .allocArray, .allocFail, .freeStrobe, .freeArray,
    .lengthWrite, .lengthArray, .lengthIndex,
    .searchStart, .searchArray, .searchKey, .searchDone, .searchResult,
    .outValid, .outData, .finished, .fault
  );

  arraySearch searcher (
    .clk, .reset, .searchStart, .searchArray, .searchKey, .searchDone, .searchResult,
    .request(searchRequest), .address(searchAddress),
    .grant(grant[peerSearch]), .dataValid(dataValid[peerSearch]), .readData,
    .queryArray, .arrayLength
  );

  arrayAllocator allocator (
    .clk, .reset, .allocStrobe, .allocArray, .allocFail, .freeStrobe, .freeArray,
    .lengthWrite, .lengthArray, .lengthIndex, .queryArray, .arrayLength
  );

  heapArbiter arbiter (
    .clk, .reset, .request, .write, .execAddress, .searchAddress, .peekAddress,
    .execData, .grant, .dataValid, .memEnable, .memWrite, .memAddress, .memIn,
    .memOut, .readData
  );

  heapMemory heap (
    .clk, .write(memWrite), .address(memAddress), .in(memIn),
    .enable(memEnable), .out(memOut)
  );

endmodule

//--- logic/arraySearch.sv
//--------------------------------------------------------------------------
// Scans one array through the heap arbiter for a key
// Result is the 1-based position of the last match below the length, else 0
//--------------------------------------------------------------------------
`timescale 1ns/100ps
`include "machine_defs.svh"

module arraySearch (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       searchStart,
  input  machinePkg::arrayNum_t      searchArray,
  input  logic [`MEM_WIDTH-1:0]      searchKey,
  output logic                       searchDone,
  output machinePkg::length_t        searchResult,
  output logic                       request,
  output logic [`HEAP_ADDR_BITS-1:0] address,
  input  logic                       grant,
  input  logic                       dataValid,
  input  logic [`MEM_WIDTH-1:0]      readData,
  output machinePkg::arrayNum_t      queryArray,
  input  machinePkg::length_t        arrayLength
);
  import machinePkg::*;

  logic                  busy;
  arrayNum_t             arrayNum;
  logic [`MEM_WIDTH-1:0] key;
  length_t               issued;                 // Reads granted so far
  length_t               received;               // Reads returned so far

  assign queryArray = arrayNum;
  assign request    = busy && issued < arrayLength;
  assign address    = `HEAP_ADDR_BITS'(arrayNum * `AREA_SIZE + issued);
  assign searchDone = busy && received == arrayLength;   // Empty array ends at once

  always_ff @(posedge clk) begin
    if (reset) begin
      busy <= 1'b0;
    end else if (searchStart) begin
      busy         <= 1'b1;
      arrayNum     <= searchArray;
      key          <= searchKey;
      issued       <= '0;
      received     <= '0;
      searchResult <= '0;
    end else if (busy) begin
      if (grant) begin
        issued <= issued + 1'b1;                 // Next read may overlap this one
      end
      if (dataValid) begin
        received <= received + 1'b1;
        if (readData == key) begin
          searchResult <= received + 1'b1;       // Later matches overwrite
        end
      end
      if (searchDone) begin
        busy <= 1'b0;
      end
    end
  end

endmodule

//--- logic/heapArbiter.sv
//--------------------------------------------------------------------------
// Round-robin heap arbiter for three peers, one grant per cycle
// Grant is combinational; read data returns the next cycle with dataValid
//--------------------------------------------------------------------------
`timescale 1ns/100ps
`include "machine_defs.svh"

module heapArbiter (
  input  logic                       clk,
  input  logic                       reset,
  input  logic [2:0]                 request,        // Indexed by heapPeer_t
  input  logic [2:0]                 write,
  input  logic [`HEAP_ADDR_BITS-1:0] execAddress,
  input  logic [`HEAP_ADDR_BITS-1:0] searchAddress,
  input  logic [`HEAP_ADDR_BITS-1:0] peekAddress,
  input  logic [`MEM_WIDTH-1:0]      execData,
  output logic [2:0]                 grant,
  output logic [2:0]                 dataValid,
  output logic                       memEnable,
  output heapPkg::heapOp_t           memWrite,
  output logic [`HEAP_ADDR_BITS-1:0] memAddress,
  output logic [`MEM_WIDTH-1:0]      memIn,
  input  logic [`MEM_WIDTH-1:0]      memOut,
  output logic [`MEM_WIDTH-1:0]      readData
);
  import heapPkg::*;

  localparam int PEERS = 3;

  heapPeer_t last;                               // Winner of the latest grant
  heapPeer_t winner;
  logic      found;
  heapPeer_t readPeer;                           // Owner of the read in flight
  logic      readPending;

  // Search starts one place after the latest winner
  always_comb begin
    winner = last;
    found  = 1'b0;
    for (int i = 1; i <= PEERS; i++) begin
      if (!found && request[(int'(last) + i) % PEERS]) begin
        winner = heapPeer_t'((int'(last) + i) % PEERS);
        found  = 1'b1;
      end
    end
  end

  always_comb begin
    case (winner)
      peerExec:   memAddress = execAddress;
      peerSearch: memAddress = searchAddress;
      default:    memAddress = peekAddress;
    endcase
  end

  assign grant     = found ? 3'b001 << winner : 3'b000;
  assign memEnable = found;
  assign memWrite  = (found && write[winner]) ? opWrite : opRead;
  assign memIn     = execData;                   // Only the executor writes
  assign dataValid = readPending ? 3'b001 << readPeer : 3'b000;
  assign readData  = memOut;

  always_ff @(posedge clk) begin
    if (reset) begin
      last        <= peerPeek;                   // Executor first after reset
      readPeer    <= peerExec;
      readPending <= 1'b0;
    end else begin
      readPending <= found && !write[winner];
      if (found) begin
        last     <= winner;
        readPeer <= winner;
      end
    end
  end

  assert property (@(posedge clk) disable iff (reset) $onehot0(grant));
  assert property (@(posedge clk) disable iff (reset) (grant & ~request) == 3'b000);

endmodule

//--- logic/heapMemory.sv
//--------------------------------------------------------------------------
// Single-port heap RAM, read data registered one cycle after enable
// Contents are not cleared by reset
//--------------------------------------------------------------------------
`timescale 1ns/100ps
`include "machine_defs.svh"

module heapMemory (
  input  logic                       clk,
  input  heapPkg::heapOp_t           write,
  input  logic [`HEAP_ADDR_BITS-1:0] address,
  input  logic [`MEM_WIDTH-1:0]      in,
  input  logic                       enable,
  output logic [`MEM_WIDTH-1:0]      out
);
  import heapPkg::*;

  localparam int HEAP_SIZE = 1 << `HEAP_ADDR_BITS;

  logic [`MEM_WIDTH-1:0] memory [HEAP_SIZE];

  always_ff @(posedge clk) begin
    if (enable) begin
      if (write == opWrite) begin
        memory[address] <= in;
      end else begin
        out <= memory[address];                  // Valid the cycle after grant
      end
    end
  end

  assert property (@(posedge clk) enable |-> !$isunknown(address) && address < HEAP_SIZE);

endmodule

//--- logic/heapPkg.sv
//--------------------------------------------------------------------------
// Heap peers and heap operations
// Peer values index the request and grant vectors of the arbiter
//--------------------------------------------------------------------------
package heapPkg;

  typedef enum logic [1:0] {
    peerExec   = 2'd0,
    peerSearch = 2'd1,
    peerPeek   = 2'd2
  } heapPeer_t;

  typedef enum logic {opRead = 1'b0, opWrite = 1'b1} heapOp_t;

endpackage

//--- logic/machinePkg.sv
//--------------------------------------------------------------------------
// Instruction set and executor types
// An instruction is one word: opcode, target local, source local, immediate
//--------------------------------------------------------------------------
`include "machine_defs.svh"

package machinePkg;

  typedef enum logic [`OPCODE_BITS-1:0] {
    opHalt, opArray, opFree, opMov, opMovWrite, opMovRead, opArrayIndex, opOut
  } opcode_t;

  typedef enum logic [2:0] {idle, fetch, heapWait, searchWait, halted} execState_t;

  typedef logic [$clog2(`ARRAY_COUNT)-1:0] arrayNum_t;   // Array number
  typedef logic [$clog2(`AREA_SIZE)-1:0]   index_t;      // Element within an area
  typedef logic [$clog2(`AREA_SIZE):0]     length_t;     // 0 to AREA_SIZE

  // ------------------------------------------------------------------------
  // Instruction field positions
  localparam int OP_MSB     = `INSTR_WIDTH - 1;
  localparam int OP_LSB     = OP_MSB - `OPCODE_BITS + 1;
  localparam int TARGET_MSB = OP_LSB - 1;
  localparam int TARGET_LSB = TARGET_MSB - `LOCAL_ADDR_BITS + 1;
  localparam int SOURCE_MSB = TARGET_LSB - 1;
  localparam int SOURCE_LSB = SOURCE_MSB - `LOCAL_ADDR_BITS + 1;
  localparam int IMM_MSB    = `MEM_WIDTH - 1;
  localparam int IMM_LSB    = 0;

endpackage

//--- logic/machine_defs.svh
//--------------------------------------------------------------------------
// Sizes shared by the array machine RTL and its testbench
// AREA_SIZE and ARRAY_COUNT must be powers of two so areas pack the heap
//--------------------------------------------------------------------------
`ifndef MACHINE_DEFS_SVH
`define MACHINE_DEFS_SVH

`define MEM_WIDTH        12                // Heap and local word
`define AREA_SIZE        4                 // Words per array area
`define ARRAY_COUNT      4                 // Live arrays at most
`define HEAP_ADDR_BITS   4                 // 16 heap words

`define LOCAL_COUNT      8
`define LOCAL_ADDR_BITS  3

`define PROG_DEPTH       32
`define PROG_ADDR_BITS   5

`define OPCODE_BITS      4
`define INSTR_WIDTH      22                // Opcode, target, source, immediate

`endif

//--- logic/programExecutor.sv
//--------------------------------------------------------------------------
// Executes the stored program one instruction at a time
// The program store is written only while reset is high; undefined opcodes
// raise fault; the program counter wraps at PROG_DEPTH
//--------------------------------------------------------------------------
`timescale 1ns/100ps
`include "machine_defs.svh"

module programExecutor (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       progWrite,
  input  logic [`PROG_ADDR_BITS-1:0] progAddress,
  input  logic [`INSTR_WIDTH-1:0]    progData,
  output logic                       heapRequest,
  output logic                       heapWrite,
  output logic [`HEAP_ADDR_BITS-1:0] heapAddress,
  output logic [`MEM_WIDTH-1:0]      heapData,
  input  logic                       heapGrant,
  input  logic                       heapDataValid,
  input  logic [`MEM_WIDTH-1:0]      heapReadData,
  output logic                       allocStrobe,
  input  machinePkg::arrayNum_t      allocArray,
  input  logic                       allocFail,
  output logic                       freeStrobe,
  output machinePkg::arrayNum_t      freeArray,
  output logic                       lengthWrite,
  output machinePkg::arrayNum_t      lengthArray,
  output machinePkg::index_t         lengthIndex,
  output logic                       searchStart,
  output machinePkg::arrayNum_t      searchArray,
  output logic [`MEM_WIDTH-1:0]      searchKey,
  input  logic                       searchDone,
  input  machinePkg::length_t        searchResult,
  output logic                       outValid,
  output logic [`MEM_WIDTH-1:0]      outData,
  output logic                       finished,
  output logic                       fault
);
  import machinePkg::*;

  logic [`INSTR_WIDTH-1:0]     progMem [`PROG_DEPTH];
  logic [`MEM_WIDTH-1:0]       localMem [`LOCAL_COUNT];
  execState_t                  state;
  logic [`PROG_ADDR_BITS-1:0]  pc;
  logic [`INSTR_WIDTH-1:0]     instr;
  opcode_t                     op;
  logic [`LOCAL_ADDR_BITS-1:0] target;
  logic [`LOCAL_ADDR_BITS-1:0] source;
  logic [`MEM_WIDTH-1:0]       imm;
  logic [`MEM_WIDTH-1:0]       targetValue;
  logic [`MEM_WIDTH-1:0]       sourceValue;
  logic                        executing;

  // Area of the array plus the element index
  function automatic logic [`HEAP_ADDR_BITS-1:0] elementAddress(
      input logic [`MEM_WIDTH-1:0] arrayWord, input logic [`MEM_WIDTH-1:0] indexWord);
    return `HEAP_ADDR_BITS'(arrayNum_t'(arrayWord) * `AREA_SIZE + index_t'(indexWord));
  endfunction

  always_ff @(posedge clk) begin
    if (reset && progWrite) begin
      progMem[progAddress] <= progData;
    end
  end

  // ------------------------------------------------------------------------
  // Decode
  assign instr       = progMem[pc];
  assign op          = opcode_t'(instr[OP_MSB:OP_LSB]);
  assign target      = instr[TARGET_MSB:TARGET_LSB];
  assign source      = instr[SOURCE_MSB:SOURCE_LSB];
  assign imm         = instr[IMM_MSB:IMM_LSB];
  assign targetValue = localMem[target];
  assign sourceValue = localMem[source];
  assign executing   = state == fetch;

  assign allocStrobe = executing && op == opArray;
  assign freeStrobe  = executing && op == opFree;
  assign freeArray   = arrayNum_t'(targetValue);
  assign lengthWrite = executing && op == opMovWrite;  // Length grows with each write
  assign lengthArray = arrayNum_t'(targetValue);
  assign lengthIndex = index_t'(imm);
  assign searchStart = executing && op == opArrayIndex;
  assign searchArray = arrayNum_t'(sourceValue);
  assign searchKey   = imm;

  // ------------------------------------------------------------------------
  // Dispatch
  always_ff @(posedge clk) begin
    if (reset) begin
      state       <= idle;
      pc          <= '0;
      heapRequest <= 1'b0;
      heapWrite   <= 1'b0;
      outValid    <= 1'b0;
      finished    <= 1'b0;
      fault       <= 1'b0;
    end else begin
      outValid <= 1'b0;
      case (state)
        idle: state <= fetch;
        fetch: begin
          case (op)
            opHalt: begin
              finished <= 1'b1;                  // Held until reset
              state    <= halted;
            end
            opArray: begin
              if (allocFail) begin
                fault <= 1'b1;
                state <= halted;
              end else begin
                localMem[target] <= `MEM_WIDTH'(allocArray);
                pc               <= pc + 1'b1;
              end
            end
            opFree: pc <= pc + 1'b1;
            opMov: begin
              localMem[target] <= imm;
              pc               <= pc + 1'b1;
            end
            opMovWrite: begin
              heapRequest <= 1'b1;
              heapWrite   <= 1'b1;
              heapAddress <= elementAddress(targetValue, imm);
              heapData    <= sourceValue;
              state       <= heapWait;
            end
            opMovRead: begin
              heapRequest <= 1'b1;
              heapWrite   <= 1'b0;
              heapAddress <= elementAddress(sourceValue, imm);
              state       <= heapWait;
            end
            opArrayIndex: state <= searchWait;
            opOut: begin
              outValid <= 1'b1;
              outData  <= sourceValue;
              pc       <= pc + 1'b1;
            end
            default: begin
              fault <= 1'b1;                     // Undefined opcode
              state <= halted;
            end
          endcase
        end
        heapWait: begin
          if (heapGrant) begin
            heapRequest <= 1'b0;
            if (heapWrite) begin
              pc    <= pc + 1'b1;                // Write done at the grant edge
              state <= fetch;
            end
          end
          if (heapDataValid) begin
            localMem[target] <= heapReadData;
            pc               <= pc + 1'b1;
            state            <= fetch;
          end
        end
        searchWait: begin
          if (searchDone) begin
            localMem[target] <= `MEM_WIDTH'(searchResult);
            pc               <= pc + 1'b1;
            state            <= fetch;
          end
        end
        default: ;                               // Halted until reset
      endcase
    end
  end

  assert property (@(posedge clk) disable iff (reset)
    state inside {idle, fetch, heapWait, searchWait, halted});

endmodule

//--- run.sh
#!/bin/sh
# Builds the array machine testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module arrayMachineTb -o simv
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

output=$(./obj_dir/simv)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "PASS: all tests"; then
  exit 0
fi
exit 1

//--- verification/arrayMachineTb.sv
//--------------------------------------------------------------------------
// Loads six array machine programs in turn and checks them with assertions
// Heap words are not reset, so later programs rely on words written earlier
//--------------------------------------------------------------------------
`timescale 1ns/100ps
`include "machine_defs.svh"

module arrayMachineTb;
  import machinePkg::*;

  localparam int TEST_COUNT  = 6;
  localparam int TEST_CYCLES = 100;              // Load, reset and run of one program
  localparam int MAX_CYCLES  = TEST_COUNT * TEST_CYCLES;
  localparam int PEEK_ADDR   = 2;                // Holds 7 from the length test

  logic                       clk;
  logic                       reset;
  logic                       progWrite;
  logic [`PROG_ADDR_BITS-1:0] progAddress;
  logic [`INSTR_WIDTH-1:0]    progData;
  logic                       peekRequest;
  logic [`HEAP_ADDR_BITS-1:0] peekAddress;
  logic                       peekGrant;
  logic                       peekValid;
  logic [`MEM_WIDTH-1:0]      peekData;
  logic                       outValid;
  logic [`MEM_WIDTH-1:0]      outData;
  logic                       finished;
  logic                       fault;

  logic [`INSTR_WIDTH-1:0] prog [$];
  logic [`MEM_WIDTH-1:0]   heapModel [1 << `HEAP_ADDR_BITS];
  logic [`MEM_WIDTH-1:0]   expectedOut [8];
  int                      expectedCount;
  int                      outCount;
  int                      peekWait;
  int                      cycles;
  int                      errors;
  int                      failedTests;
  logic                    expectFault;
  string                   testName;
  integer                  seed;

  arrayMachine DUT (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // ------------------------------------------------------------------------
  // Counters sampled by the assertions
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (reset) begin
      outCount <= 0;
    end else if (outValid) begin
      outCount <= outCount + 1;
    end
    peekWait <= (peekRequest && !peekGrant) ? peekWait + 1 : 0;
  end

  always @(posedge clk) begin
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout after %0d cycles in test %s", cycles, testName);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  // ------------------------------------------------------------------------
  // Checks
  assert property (@(posedge clk) $fell(reset) |-> !finished && !outValid && !fault
                   && !peekGrant)
    else begin
      $display("%s: an output was high right after reset", testName);
      errors++;
    end

  assert property (@(posedge clk) disable iff (reset) outValid |-> outCount < expectedCount)
    else begin
      $display("%s: more outputs than the program emits", testName);
      errors++;
    end

  assert property (@(posedge clk) disable iff (reset)
                   outValid && outCount < expectedCount |-> outData == expectedOut[outCount])
    else begin
      $display("CHECK FAILED %s: outData expected %0d, actual %0d", testName,
               $sampled(expectedOut[outCount]), $sampled(outData));
      errors++;
    end

  assert property (@(posedge clk) disable iff (reset) fault |-> expectFault)
    else begin
      $display("%s: fault raised without an allocation overflow", testName);
      errors++;
    end

  assert property (@(posedge clk) disable iff (reset) finished |-> !expectFault)
    else begin
      $display("%s: finished raised although the program must fault", testName);
      errors++;
    end

  assert property (@(posedge clk) disable iff (reset) peekWait <= 3)
    else begin
      $display("%s: peek request waited more than 3 cycles", testName);
      errors++;
    end

  assert property (@(posedge clk) disable iff (reset)
                   peekValid |-> peekData == heapModel[peekAddress])
    else begin
      $display("CHECK FAILED %s: peekData expected %0d, actual %0d", testName,
               $sampled(heapModel[peekAddress]), $sampled(peekData));
      errors++;
    end

  // ------------------------------------------------------------------------
  // Program assembly
  function automatic logic [`INSTR_WIDTH-1:0] encode(opcode_t op, int target, int source,
                                                     int imm);
    logic [`INSTR_WIDTH-1:0] word;
    word = '0;
    word[OP_MSB:OP_LSB]         = op;
    word[TARGET_MSB:TARGET_LSB] = target[`LOCAL_ADDR_BITS-1:0];
    word[SOURCE_MSB:SOURCE_LSB] = source[`LOCAL_ADDR_BITS-1:0];
    word[IMM_MSB:IMM_LSB]       = imm[`MEM_WIDTH-1:0];
    return word;
  endfunction

  task automatic startProgram(string name);
    testName      = name;
    expectedCount = 0;
    expectFault   = 1'b0;
    prog.delete();
  endtask

  task automatic expectOutput(int value);
    expectedOut[expectedCount] = value[`MEM_WIDTH-1:0];
    expectedCount++;
  endtask

  // Loads a value into a local, stores it as an element and records it
  task automatic storeElement(int arrayReg, int arrayNum, int index, int value);
    prog.push_back(encode(opMov, 1, 0, value));
    prog.push_back(encode(opMovWrite, arrayReg, 1, index));
    heapModel[arrayNum * `AREA_SIZE + index] = value[`MEM_WIDTH-1:0];
  endtask

  task automatic peekLoop();
    @(negedge clk);                              // Grants stay low in the first cycle
    while (!finished && !fault) begin
      peekAddress = `HEAP_ADDR_BITS'(PEEK_ADDR);
      peekRequest = 1'b1;
      #1;
      while (!peekGrant) begin
        @(negedge clk);
        #1;
      end
      @(negedge clk);
      peekRequest = 1'b0;
      @(negedge clk);
    end
  endtask

  task automatic runProgram(logic withPeek);
    int errorsBefore;
    errorsBefore = errors;
    @(negedge clk);
    reset = 1'b1;
    prog.push_back(encode(opHalt, 0, 0, 0));
    foreach (prog[i]) begin
      progWrite   = 1'b1;
      progAddress = i[`PROG_ADDR_BITS-1:0];
      progData    = prog[i];
      @(negedge clk);
    end
    progWrite = 1'b0;
    repeat (2) @(negedge clk);
    reset = 1'b0;
    fork
      begin
        do @(negedge clk); while (!finished && !fault);
      end
      begin
        if (withPeek) peekLoop();
      end
    join
    repeat (3) @(negedge clk);
    assert (outCount == expectedCount)
      else begin
        $display("CHECK FAILED %s: output count expected %0d, actual %0d", testName,
                 expectedCount, outCount);
        errors++;
      end
    assert (expectFault ? (fault && !finished) : (finished && !fault))
      else begin
        $display("%s: program did not end as expected", testName);
        errors++;
      end
    if (errors != errorsBefore) failedTests++;
    $display("%s: %s", testName, (errors == errorsBefore) ? "ok" : "failed");
    reset = 1'b1;                                // Machine held until the next program
  endtask

  // ------------------------------------------------------------------------
  // Tests
  initial begin
    logic [`MEM_WIDTH-1:0] values [3];
    logic [`MEM_WIDTH-1:0] missing;
    reset       = 1'b1;
    progWrite   = 1'b0;
    progAddress = '0;
    progData    = '0;
    peekRequest = 1'b0;
    peekAddress = '0;
    cycles      = 0;
    errors      = 0;
    failedTests = 0;
    outCount    = 0;
    peekWait    = 0;
    seed        = 82;
    repeat (2) @(negedge clk);

    startProgram("basicSearch");
    prog.push_back(encode(opArray, 0, 0, 0));
    storeElement(0, 0, 0, 10);
    storeElement(0, 0, 1, 20);
    storeElement(0, 0, 2, 30);
    prog.push_back(encode(opArrayIndex, 2, 0, 20));
    prog.push_back(encode(opOut, 0, 2, 0));
    expectOutput(2);
    runProgram(1'b0);

    startProgram("randomElements");
    prog.push_back(encode(opArray, 0, 0, 0));
    for (int i = 0; i < 3; i++) begin
      values[i] = `MEM_WIDTH'($random(seed));
      storeElement(0, 0, i, int'(values[i]));
    end
    for (int i = 0; i < 3; i++) begin
      prog.push_back(encode(opMovRead, 2, 0, i));
      prog.push_back(encode(opOut, 0, 2, 0));
      expectOutput(int'(values[i]));
    end
    missing = values[0] + 1'b1;
    while (missing == values[0] || missing == values[1] || missing == values[2]) begin
      missing = missing + 1'b1;
    end
    prog.push_back(encode(opArrayIndex, 3, 0, int'(missing)));
    prog.push_back(encode(opOut, 0, 3, 0));
    expectOutput(0);
    runProgram(1'b0);

    startProgram("arrayReuse");
    prog.push_back(encode(opArray, 0, 0, 0));
    prog.push_back(encode(opArray, 1, 0, 0));
    prog.push_back(encode(opFree, 0, 0, 0));
    prog.push_back(encode(opArray, 2, 0, 0));
    prog.push_back(encode(opOut, 0, 0, 0));
    prog.push_back(encode(opOut, 0, 2, 0));
    expectOutput(0);                             // First array of a fresh machine
    expectOutput(0);                             // Freed one comes back
    runProgram(1'b0);

    startProgram("allocOverflow");
    expectFault = 1'b1;
    for (int i = 0; i <= `ARRAY_COUNT; i++) begin
      prog.push_back(encode(opArray, i, 0, 0));
    end
    runProgram(1'b0);

    startProgram("lengthRule");
    prog.push_back(encode(opArray, 0, 0, 0));
    for (int i = 0; i < `AREA_SIZE; i++) begin
      storeElement(0, 0, i, 0);
    end
    prog.push_back(encode(opFree, 0, 0, 0));
    prog.push_back(encode(opArray, 0, 0, 0));    // Reused area starts with length zero
    storeElement(0, 0, 2, 7);
    prog.push_back(encode(opArrayIndex, 2, 0, 0));
    prog.push_back(encode(opOut, 0, 2, 0));
    expectOutput(2);
    runProgram(1'b0);

    startProgram("peekContention");
    prog.push_back(encode(opArray, 0, 0, 0));
    prog.push_back(encode(opArray, 3, 0, 0));
    storeElement(3, 1, 0, 5);
    storeElement(3, 1, 1, 9);
    storeElement(3, 1, 2, 5);
    prog.push_back(encode(opArrayIndex, 2, 3, 5));
    prog.push_back(encode(opOut, 0, 2, 0));
    expectOutput(3);
    runProgram(1'b1);

    $display("Tests run %0d, tests failed %0d, check errors %0d", TEST_COUNT, failedTests,
             errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule
